//--- alu_exec.f
+incdir+include
design/alu_pkg.sv
design/alu_ctrl.sv
design/alu_stage_regs.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu_result_sel.sv
design/alu_exec.sv
tests/alu_exec_tb.sv

//--- design/alu_adder.sv
/*
 * ALU add/subtract datapath
 * Sum, difference, signed and unsigned compare, pc plus op2
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_adder (
  input  alu_pkg::dx_msg_t      x0_msg,
  output logic [`ALU_XLEN-1:0]  sum,
  output logic [`ALU_XLEN-1:0]  diff,
  output logic                  lt_s,
  output logic                  lt_u,
  output logic [`ALU_XLEN-1:0]  pc_sum
);

  // Carry out of op1 + ~op2 + 1
  logic borrow_n;
  logic sign_a;
  logic sign_b;

  assign sign_a = x0_msg.op1[`ALU_XLEN-1];
  assign sign_b = x0_msg.op2[`ALU_XLEN-1];

  // Plain add
  assign sum = x0_msg.op1 + x0_msg.op2;

  // Subtract as two's complement add, keep the carry
  assign {borrow_n, diff} = {1'b0, x0_msg.op1} + {1'b0, ~x0_msg.op2} + 1'b1;

  // No carry means op1 below op2 unsigned
  assign lt_u = !borrow_n;

  // Signs differ: negative operand is smaller
  // Signs equal: difference sign decides, no overflow possible
  assign lt_s = (sign_a != sign_b) ? sign_a : diff[`ALU_XLEN-1];

  // auipc target
  assign pc_sum = x0_msg.pc + x0_msg.op2;

endmodule

`default_nettype wire

//--- design/alu_ctrl.sv
/*
 * ALU pipeline control
 * Tracks operand and writeback stage valids, builds the
 * stall chain from out_rdy back to in_rdy
 */

`timescale 1ns/1ps
`default_nettype none

module alu_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_val,
  output logic in_rdy,
  input  logic out_rdy,
  output logic out_val,
  output logic ld_x0,
  output logic ld_x1
);

  // Stage valid bits
  logic x0_val;
  logic x1_val;

  // Advance conditions
  logic x1_adv;
  logic x0_adv;

  // ------------------------------
  // Stall chain
  // ------------------------------

  // Writeback slot frees when empty or drained downstream
  assign x1_adv = !x1_val || out_rdy;
  // Operand stage follows writeback
  assign x0_adv = x1_adv;
  // Never looks at in_val
  assign in_rdy = !x0_val || x0_adv;

  assign ld_x0   = in_val && in_rdy;
  assign ld_x1   = x0_val && x1_adv;
  assign out_val = x1_val;

  // ------------------------------
  // Valid tracking
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x0_val <= 1'b0;
      x1_val <= 1'b0;
    end else begin
      // Operand slot refilled or emptied whenever it is free to move
      if (in_rdy) begin
        x0_val <= in_val;
      end
      // Writeback slot takes whatever the operand stage holds
      if (x1_adv) begin
        x1_val <= x0_val;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/alu_exec.sv
/*
 * ALU execute unit top
 * Two-stage val/rdy pipeline from decode to writeback
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_exec (
  input  logic              clk,
  input  logic              rst_n,
  // Decode side
  input  logic              in_val,
  output logic              in_rdy,
  input  alu_pkg::dx_msg_t  in_msg,
  // Writeback side
  output logic              out_val,
  input  logic              out_rdy,
  output alu_pkg::xw_msg_t  out_msg
);

  // Stage load enables
  logic ld_x0;
  logic ld_x1;

  // Held operand message and next result
  alu_pkg::dx_msg_t x0_msg;
  alu_pkg::xw_msg_t wb_next;

  // Datapath results
  logic [`ALU_XLEN-1:0] sum;
  logic [`ALU_XLEN-1:0] diff;
  logic [`ALU_XLEN-1:0] pc_sum;
  logic [`ALU_XLEN-1:0] shamt_out;
  logic                 lt_s;
  logic                 lt_u;

  // ------------------------------
  // Control
  // ------------------------------
  alu_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .out_rdy (out_rdy),
    .out_val (out_val),
    .ld_x0   (ld_x0),
    .ld_x1   (ld_x1)
  );

  // ------------------------------
  // Pipeline registers
  // ------------------------------
  alu_stage_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .ld_x0   (ld_x0),
    .ld_x1   (ld_x1),
    .in_msg  (in_msg),
    .wb_next (wb_next),
    .x0_msg  (x0_msg),
    .out_msg (out_msg)
  );

  // ------------------------------
  // Datapath
  // ------------------------------
  alu_adder u_adder (
    .x0_msg (x0_msg),
    .sum    (sum),
    .diff   (diff),
    .lt_s   (lt_s),
    .lt_u   (lt_u),
    .pc_sum (pc_sum)
  );

  alu_shifter u_shifter (
    .x0_msg    (x0_msg),
    .shamt_out (shamt_out)
  );

  alu_result_sel u_result_sel (
    .x0_msg    (x0_msg),
    .sum       (sum),
    .diff      (diff),
    .pc_sum    (pc_sum),
    .shamt_out (shamt_out),
    .lt_s      (lt_s),
    .lt_u      (lt_u),
    .wb_next   (wb_next)
  );

endmodule

`default_nettype wire

//--- design/alu_pkg.sv
/*
 * ALU execute package
 * Micro-op encoding and the decode/writeback message structs
 */

`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

  // ------------------------------
  // Micro-ops
  // ------------------------------
  typedef enum logic [3:0] {
    UOP_ADD   = 4'd0,
    UOP_SUB   = 4'd1,
    UOP_AND   = 4'd2,
    UOP_OR    = 4'd3,
    UOP_XOR   = 4'd4,
    UOP_SLT   = 4'd5,
    UOP_SLTU  = 4'd6,
    UOP_SLL   = 4'd7,
    UOP_SRL   = 4'd8,
    UOP_SRA   = 4'd9,
    UOP_LUI   = 4'd10,
    UOP_AUIPC = 4'd11
  } uop_e;

  // ------------------------------
  // Messages
  // ------------------------------

  // Decode to execute
  typedef struct packed {
    logic [`ALU_XLEN-1:0]       pc;
    logic [`ALU_SEQ_BITS-1:0]   seq_num;
    logic [`ALU_XLEN-1:0]       op1;
    logic [`ALU_XLEN-1:0]       op2;
    logic [`ALU_RADDR_BITS-1:0] waddr;
    uop_e                       uop;
  } dx_msg_t;

  // Execute to writeback
  typedef struct packed {
    logic [`ALU_XLEN-1:0]       pc;
    logic [`ALU_SEQ_BITS-1:0]   seq_num;
    logic [`ALU_RADDR_BITS-1:0] waddr;
    logic [`ALU_XLEN-1:0]       wdata;
    logic                       wen;
  } xw_msg_t;

endpackage

`default_nettype wire

//--- design/alu_result_sel.sv
/*
 * ALU result select
 * Logic ops, wdata mux by micro-op and write enable,
 * packed into the next writeback message
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_result_sel (
  input  alu_pkg::dx_msg_t      x0_msg,
  input  logic [`ALU_XLEN-1:0]  sum,
  input  logic [`ALU_XLEN-1:0]  diff,
  input  logic [`ALU_XLEN-1:0]  pc_sum,
  input  logic [`ALU_XLEN-1:0]  shamt_out,
  input  logic                  lt_s,
  input  logic                  lt_u,
  output alu_pkg::xw_msg_t      wb_next
);

  logic [`ALU_XLEN-1:0] and_q;
  logic [`ALU_XLEN-1:0] or_q;
  logic [`ALU_XLEN-1:0] xor_q;
  logic [`ALU_XLEN-1:0] wdata;

  // ------------------------------
  // Bitwise ops
  // ------------------------------
  assign and_q = x0_msg.op1 & x0_msg.op2;
  assign or_q  = x0_msg.op1 | x0_msg.op2;
  assign xor_q = x0_msg.op1 ^ x0_msg.op2;

  // ------------------------------
  // Result mux
  // ------------------------------
  always_comb begin
    unique case (x0_msg.uop)
      alu_pkg::UOP_ADD:   wdata = sum;
      alu_pkg::UOP_SUB:   wdata = diff;
      alu_pkg::UOP_AND:   wdata = and_q;
      alu_pkg::UOP_OR:    wdata = or_q;
      alu_pkg::UOP_XOR:   wdata = xor_q;
      // Compare results zero-extended to 0/1
      alu_pkg::UOP_SLT:   wdata = {{(`ALU_XLEN-1){1'b0}}, lt_s};
      alu_pkg::UOP_SLTU:  wdata = {{(`ALU_XLEN-1){1'b0}}, lt_u};
      // All three shifts share one shifter
      alu_pkg::UOP_SLL,
      alu_pkg::UOP_SRL,
      alu_pkg::UOP_SRA:   wdata = shamt_out;
      // Upper immediate already formed by decode
      alu_pkg::UOP_LUI:   wdata = x0_msg.op2;
      alu_pkg::UOP_AUIPC: wdata = pc_sum;
      default:            wdata = '0;
    endcase
  end

  // ------------------------------
  // Writeback message
  // ------------------------------
  always_comb begin
    wb_next.pc      = x0_msg.pc;
    wb_next.seq_num = x0_msg.seq_num;
    wb_next.waddr   = x0_msg.waddr;
    wb_next.wdata   = wdata;
    // x0 is hardwired, suppress the write
    wb_next.wen     = |x0_msg.waddr;
  end

endmodule

`default_nettype wire

//--- design/alu_shifter.sv
/*
 * ALU barrel shifter
 * Five-level right shifter, left shift by reversing around it
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_shifter (
  input  alu_pkg::dx_msg_t      x0_msg,
  output logic [`ALU_XLEN-1:0]  shamt_out
);

  localparam int LVLS = $clog2(`ALU_XLEN);

  logic                 is_left;
  logic                 fill;
  logic [LVLS-1:0]      shamt;
  logic [`ALU_XLEN-1:0] op_rev;
  logic [`ALU_XLEN-1:0] res_rev;
  logic [`ALU_XLEN-1:0] lvl_q [0:LVLS];

  assign is_left = (x0_msg.uop == alu_pkg::UOP_SLL);
  // Sign fill only for arithmetic right
  assign fill    = (x0_msg.uop == alu_pkg::UOP_SRA) && x0_msg.op1[`ALU_XLEN-1];
  // Low bits of op2 only
  assign shamt   = x0_msg.op2[LVLS-1:0];

  // Bit reversal of input and result
  always_comb begin
    for (int i = 0; i < `ALU_XLEN; i++) begin
      op_rev[i]  = x0_msg.op1[`ALU_XLEN-1-i];
      res_rev[i] = lvl_q[LVLS][`ALU_XLEN-1-i];
    end
  end

  assign lvl_q[0] = is_left ? op_rev : x0_msg.op1;

  // ------------------------------
  // Shift levels 1, 2, 4, 8, 16
  // ------------------------------
  for (genvar lvl = 0; lvl < LVLS; lvl++) begin : g_lvl
    localparam int SH = 1 << lvl;
    assign lvl_q[lvl+1] = shamt[lvl] ? {{SH{fill}}, lvl_q[lvl][`ALU_XLEN-1:SH]} : lvl_q[lvl];
  end

  assign shamt_out = is_left ? res_rev : lvl_q[LVLS];

endmodule

`default_nettype wire

//--- design/alu_stage_regs.sv
/*
 * ALU pipeline registers
 * Operand stage and writeback stage, each loaded on its enable
 */

`timescale 1ns/1ps
`default_nettype none

module alu_stage_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ld_x0,
  input  logic              ld_x1,
  input  alu_pkg::dx_msg_t  in_msg,
  input  alu_pkg::xw_msg_t  wb_next,
  output alu_pkg::dx_msg_t  x0_msg,
  output alu_pkg::xw_msg_t  out_msg
);

  // ------------------------------
  // Operand stage
  // ------------------------------

  // Holds the accepted decode message, stable under stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x0_msg <= '0;
    end else if (ld_x0) begin
      x0_msg <= in_msg;
    end
  end

  // ------------------------------
  // Writeback stage
  // ------------------------------

  // Result register feeding out_msg
  // Kept unchanged while out_rdy is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_msg <= '0;
    end else if (ld_x1) begin
      out_msg <= wb_next;
    end
  end

endmodule

`default_nettype wire

//--- include/alu_consts.svh
/*
 * ALU execute unit widths
 * Data, sequence number and register address sizes
 */

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Data path width
`define ALU_XLEN 32

// Sequence number width, matches decode tagging
`define ALU_SEQ_BITS 5

// Architectural register address width
`define ALU_RADDR_BITS 5

`endif

//--- tests/alu_exec_tb.sv
/*
 * ALU execute unit testbench
 * Directed tests plus a random back-pressure run, checked against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_exec_tb;

  // Directed ops plus the random run
  localparam int NUM_OPS        = 27 + 40;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 8 + 50;

  logic             clk;
  logic             rst_n;
  logic             in_val;
  logic             in_rdy;
  alu_pkg::dx_msg_t in_msg;
  logic             out_val;
  logic             out_rdy;
  alu_pkg::xw_msg_t out_msg;

  // Expected results in issue order
  alu_pkg::xw_msg_t exp_q[$];
  alu_pkg::xw_msg_t held_msg;
  logic             stalled;
  logic             rdy_random;
  logic             rdy_next;
  logic [`ALU_SEQ_BITS-1:0] seq_ctr;
  integer           seed = 32'h7fbd_b29d;

  alu_exec u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic compare_xw_msg(input string name, input alu_pkg::xw_msg_t exp,
                                input alu_pkg::xw_msg_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic alu_pkg::xw_msg_t expect_result(input alu_pkg::dx_msg_t m);
    alu_pkg::xw_msg_t r;
    logic [4:0]       sh;
    // Shift amount is the low five bits only
    sh        = m.op2[4:0];
    r.pc      = m.pc;
    r.seq_num = m.seq_num;
    r.waddr   = m.waddr;
    r.wen     = (m.waddr != 0);
    case (m.uop)
      alu_pkg::UOP_ADD:   r.wdata = m.op1 + m.op2;
      alu_pkg::UOP_SUB:   r.wdata = m.op1 - m.op2;
      alu_pkg::UOP_AND:   r.wdata = m.op1 & m.op2;
      alu_pkg::UOP_OR:    r.wdata = m.op1 | m.op2;
      alu_pkg::UOP_XOR:   r.wdata = m.op1 ^ m.op2;
      alu_pkg::UOP_SLT:   r.wdata = ($signed(m.op1) < $signed(m.op2)) ? 32'd1 : 32'd0;
      alu_pkg::UOP_SLTU:  r.wdata = (m.op1 < m.op2) ? 32'd1 : 32'd0;
      alu_pkg::UOP_SLL:   r.wdata = m.op1 << sh;
      alu_pkg::UOP_SRL:   r.wdata = m.op1 >> sh;
      alu_pkg::UOP_SRA:   r.wdata = $signed(m.op1) >>> sh;
      alu_pkg::UOP_LUI:   r.wdata = m.op2;
      alu_pkg::UOP_AUIPC: r.wdata = m.pc + m.op2;
      default:            r.wdata = '0;
    endcase
    return r;
  endfunction

  function automatic alu_pkg::dx_msg_t make_op(input alu_pkg::uop_e uop,
      input logic [31:0] op1, input logic [31:0] op2, input logic [4:0] waddr,
      input logic [31:0] pc);
    alu_pkg::dx_msg_t m;
    m.pc      = pc;
    m.seq_num = '0;
    m.op1     = op1;
    m.op2     = op2;
    m.waddr   = waddr;
    m.uop     = uop;
    return m;
  endfunction

  function automatic alu_pkg::dx_msg_t random_op();
    alu_pkg::uop_e uop;
    uop = alu_pkg::uop_e'($unsigned($random(seed)) % 12);
    return make_op(uop, $random(seed), $random(seed), $random(seed), $random(seed));
  endfunction

  // ------------------------------
  // Drivers, all entered at posedge + 1 ns
  // ------------------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Hold val and message until the transfer edge
  task automatic send_op(input alu_pkg::dx_msg_t m);
    m.seq_num = seq_ctr;
    seq_ctr++;
    in_msg = m;
    in_val = 1'b1;
    @(negedge clk);
    while (!in_rdy) @(negedge clk);
    exp_q.push_back(expect_result(m));
    @(posedge clk);
    #1;
    in_val = 1'b0;
  endtask

  // Wait for every expected result, then one quiet cycle for strays
  task automatic drain();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
    @(posedge clk);
    #1;
  endtask

  // Empty pipe, out_rdy high, transfer out two edges after acceptance
  task automatic run_single(input alu_pkg::dx_msg_t m);
    send_op(m);
    @(negedge clk);
    compare_bit("out_val", 1'b0, out_val);
    @(negedge clk);
    compare_bit("out_val", 1'b1, out_val);
    drain();
  endtask

  // out_rdy random only during the back-pressure run
  // Drawn at the falling edge, driven after the rising edge
  always @(negedge clk) begin
    rdy_next = rdy_random ? $random(seed) : 1'b1;
  end

  always @(posedge clk) begin
    #1;
    out_rdy = rdy_next;
  end

  // ------------------------------
  // Output checker
  // ------------------------------
  always @(negedge clk) begin
    // Stalled result must not move
    if (stalled) begin
      compare_bit("out_val", 1'b1, out_val);
      compare_xw_msg("out_msg held", held_msg, out_msg);
    end
    stalled  = out_val && !out_rdy;
    held_msg = out_msg;
    if (out_val && out_rdy) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: output transfer with no operation outstanding", $time);
        $display("Simulation finished: FAIL");
        $fatal(1);
      end else begin
        compare_xw_msg("out_msg", exp_q.pop_front(), out_msg);
      end
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic check_reset();
    rst_n = 1'b0;
    repeat (10) begin
      @(negedge clk);
      compare_bit("out_val", 1'b0, out_val);
      compare_bit("in_rdy", 1'b1, in_rdy);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    compare_bit("out_val", 1'b0, out_val);
    compare_bit("in_rdy", 1'b1, in_rdy);
    @(posedge clk);
    #1;
  endtask

  task automatic test_arith();
    run_single(make_op(alu_pkg::UOP_ADD, 32'h7fff_ffff, 32'h1, 5'd1, 32'h100));
    run_single(make_op(alu_pkg::UOP_ADD, 32'hffff_ffff, 32'h1, 5'd2, 32'h104));
    run_single(make_op(alu_pkg::UOP_SUB, 32'h0, 32'h1, 5'd3, 32'h108));
    run_single(make_op(alu_pkg::UOP_SUB, 32'h8000_0000, 32'h1, 5'd4, 32'h10c));
    run_single(make_op(alu_pkg::UOP_LUI, 32'h1234_5678, 32'hdead_b000, 5'd5, 32'h110));
    // pc plus op2 wraps past zero
    run_single(make_op(alu_pkg::UOP_AUIPC, 32'h0, 32'h20, 5'd6, 32'hffff_fff0));
  endtask

  task automatic test_compare();
    run_single(make_op(alu_pkg::UOP_SLT, 32'h55, 32'h55, 5'd7, 32'h200));
    run_single(make_op(alu_pkg::UOP_SLTU, 32'h55, 32'h55, 5'd8, 32'h204));
    run_single(make_op(alu_pkg::UOP_SLT, 32'h8000_0000, 32'h1, 5'd9, 32'h208));
    run_single(make_op(alu_pkg::UOP_SLTU, 32'h8000_0000, 32'h1, 5'd10, 32'h20c));
    run_single(make_op(alu_pkg::UOP_SLT, 32'hffff_ffff, 32'h0, 5'd11, 32'h210));
    run_single(make_op(alu_pkg::UOP_SLTU, 32'hffff_ffff, 32'h0, 5'd12, 32'h214));
  endtask

  task automatic test_logic_shift();
    run_single(make_op(alu_pkg::UOP_AND, 32'hf0f0_a5a5, 32'h0ff0_ffff, 5'd13, 32'h300));
    run_single(make_op(alu_pkg::UOP_OR, 32'hf0f0_a5a5, 32'h0ff0_0000, 5'd14, 32'h304));
    run_single(make_op(alu_pkg::UOP_XOR, 32'hf0f0_a5a5, 32'hffff_0000, 5'd15, 32'h308));
    run_single(make_op(alu_pkg::UOP_SLL, 32'h8765_4321, 32'd0, 5'd16, 32'h30c));
    run_single(make_op(alu_pkg::UOP_SLL, 32'h8765_4321, 32'd31, 5'd17, 32'h310));
    run_single(make_op(alu_pkg::UOP_SLL, 32'h8765_4321, 32'd37, 5'd18, 32'h314));
    run_single(make_op(alu_pkg::UOP_SRL, 32'h8765_4321, 32'd0, 5'd19, 32'h318));
    run_single(make_op(alu_pkg::UOP_SRL, 32'h8765_4321, 32'd31, 5'd20, 32'h31c));
    run_single(make_op(alu_pkg::UOP_SRL, 32'h8765_4321, 32'd33, 5'd21, 32'h320));
    // Negative operand, fill with ones
    run_single(make_op(alu_pkg::UOP_SRA, 32'h8000_0f00, 32'd4, 5'd22, 32'h324));
    run_single(make_op(alu_pkg::UOP_SRA, 32'h8000_0f00, 32'd31, 5'd23, 32'h328));
    run_single(make_op(alu_pkg::UOP_SRA, 32'h8765_4321, 32'd36, 5'd24, 32'h32c));
    run_single(make_op(alu_pkg::UOP_SRA, 32'h8000_0f00, 32'd0, 5'd25, 32'h330));
  endtask

  task automatic test_wen();
    // x0 target still carries wdata
    run_single(make_op(alu_pkg::UOP_ADD, 32'h10, 32'h20, 5'd0, 32'h400));
    run_single(make_op(alu_pkg::UOP_ADD, 32'h10, 32'h20, 5'd31, 32'h404));
  endtask

  task automatic test_backpressure();
    int gap;
    rdy_random = 1'b1;
    for (int i = 0; i < 40; i++) begin
      gap = $unsigned($random(seed)) % 3;
      idle(gap);
      send_op(random_op());
    end
    rdy_random = 1'b0;
    drain();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_val     = 1'b0;
    in_msg     = '0;
    out_rdy    = 1'b1;
    rdy_random = 1'b0;
    rdy_next   = 1'b1;
    stalled    = 1'b0;
    held_msg   = '0;
    seq_ctr    = '0;
    check_reset();
    test_arith();
    test_compare();
    test_logic_shift();
    test_wen();
    test_backpressure();
    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Error: timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire
